// ==== project.f ====
+incdir+source
source/mipsCtrlPkg.sv
source/decodeIf.sv
source/instDecoder.sv
source/ctrlFsm.sv
source/ctrlSignals.sv
source/mipsCtrl.sv
testbench/mipsCtrlTb.sv

// ==== testbench/mipsCtrlTb.sv ====
`timescale 1ns/1ps
`include "mipsCtrl_macros.svh"

module mipsCtrlTb
    import mipsCtrlPkg::*;
();

    // about five times the longest expected run
    localparam int TIMEOUT = 2000;
    localparam int ACK_INST_REQ = 0, ACK_INST_VALID = 1, ACK_MEM = 2, ACK_READ = 3;
    localparam int LVL_INST_REQ = 0, LVL_INST_ACK = 1, LVL_MEM_READ = 2;
    localparam int LVL_READ_ACK = 3, LVL_MEM_WRITE = 4;

    logic clk, rst, specialJump, instReqAck, instValid, memReqAck, readDataValid;
    logic [`WORD_W-1:0] instruction;
    logic [`BRANCH_W-1:0] branchCond;
    logic pcWrite, memRead, memWrite, regWrite, aWrite, bWrite, instructionWrite;
    logic aluSrcA, aluOpSrc, aluWrite, memWriteSrc, iorD;
    logic instReqValid, instAck, readDataAck, readDataWrite;
    aluSrcBT aluSrcB;
    pcSrcT pcSrc;
    regWriteSrcT regWriteSrc;
    regDstT regDst;
    logic [`ALUOP_W-1:0] aluOpC;

    int checks, errors, cycles;
    logic [31:0] lcgState = 32'd19386;

    mipsCtrl dut0 (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // 0 to 3 cycles from the upper bits
    function automatic int randDelay();
        return int'(lcgNext() >> 30);
    endfunction

    function automatic logic levelOf(input int sel);
        case (sel)
            LVL_INST_REQ:  return instReqValid;
            LVL_INST_ACK:  return instAck;
            LVL_MEM_READ:  return memRead;
            LVL_READ_ACK:  return readDataAck;
            LVL_MEM_WRITE: return memWrite;
            default:       return 1'b0;
        endcase
    endfunction

    task automatic checkVal(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic setAck(input int which, input logic value);
        case (which)
            ACK_INST_REQ:   instReqAck <= value;
            ACK_INST_VALID: instValid <= value;
            ACK_MEM:        memReqAck <= value;
            default:        readDataValid <= value;
        endcase
    endtask

    // one-cycle acknowledge so the state moves on the second edge
    task automatic driveAck(input int which);
        @(posedge clk);
        setAck(which, 1'b1);
        @(posedge clk);
        setAck(which, 1'b0);
    endtask

    // a wait state must hold its request level while no acknowledge comes
    task automatic holdLevel(input string name, input int sel, input int n);
        repeat (n)
        begin
            @(posedge clk);
            @(negedge clk);
            checkVal(name, levelOf(sel), 1'b1);
        end
    endtask

    // ends at the negative edge inside Decode
    task automatic fetchDecode(input logic [31:0] instr);
        @(negedge clk);
        while (!instReqValid)
            @(negedge clk);
        holdLevel("instReqValid", LVL_INST_REQ, randDelay());
        driveAck(ACK_INST_REQ);
        instruction <= instr;
        @(negedge clk);
        checkVal("instAck", instAck, 1'b1);
        checkVal("instructionWrite", instructionWrite, 1'b1);
        holdLevel("instAck", LVL_INST_ACK, randDelay());
        driveAck(ACK_INST_VALID);
        @(negedge clk);
        checkVal("instructionWrite", instructionWrite, 1'b0);
        checkVal("pcWrite", pcWrite, 1'b0);
        checkVal("aWrite", aWrite, 1'b1);
        checkVal("bWrite", bWrite, 1'b1);
    endtask

    task automatic expectFetch();
        @(negedge clk);
        checkVal("instReqValid", instReqValid, 1'b1);
        checkVal("iorD", iorD, `IORD_PC);
        checkVal("pcWrite", pcWrite, 1'b0);
        checkVal("regWrite", regWrite, 1'b0);
        checkVal("memRead", memRead, 1'b0);
        checkVal("memWrite", memWrite, 1'b0);
        checkVal("aWrite", aWrite, 1'b0);
        checkVal("instructionWrite", instructionWrite, 1'b0);
    endtask

    task automatic resetTest();
        int waited;
        repeat (16)
        begin
            @(negedge clk);
            checkVal("instAck", instAck, 1'b1);
            checkVal("instReqValid", instReqValid, 1'b0);
            checkVal("strobes", {pcWrite, memRead, memWrite, regWrite, aWrite, bWrite,
                                 instructionWrite, aluWrite, readDataWrite}, '0);
        end
        @(posedge clk);
        rst <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!instReqValid && waited < 2)
        begin
            waited++;
            @(negedge clk);
        end
        checkVal("instReqValid", instReqValid, 1'b1);
    endtask

    task automatic rTypeTest(input logic [5:0] funct, input logic sj, input logic srcA,
                             input aluSrcBT srcB);
        @(posedge clk);
        specialJump <= sj;
        fetchDecode({`OP_SPECIAL, 5'd4, 5'd5, 5'd6, 5'd0, funct});
        @(negedge clk);
        checkVal("aluWrite", aluWrite, 1'b1);
        checkVal("pcSrc", pcSrc, PcA);
        checkVal("pcWrite", pcWrite, sj);
        checkVal("aluSrcA", aluSrcA, srcA);
        checkVal("aluSrcB", aluSrcB, srcB);
        checkVal("aluOpSrc", aluOpSrc, `OPSRC_FUNCT);
        @(negedge clk);
        checkVal("regWrite", regWrite, 1'b1);
        checkVal("regDst", regDst, Rd);
        expectFetch();
    endtask

    task automatic immTest(input logic [5:0] op, input logic [2:0] alu, input aluSrcBT srcB);
        logic [31:0] rnd;
        rnd = lcgNext();
        fetchDecode({op, 5'd2, 5'd3, rnd[31:16]});
        @(negedge clk);
        checkVal("aluOpC", aluOpC, alu);
        checkVal("aluSrcB", aluSrcB, srcB);
        checkVal("aluSrcA", aluSrcA, `SRCA_A);
        checkVal("aluOpSrc", aluOpSrc, `OPSRC_CTRL);
        @(negedge clk);
        checkVal("regWrite", regWrite, 1'b1);
        checkVal("regDst", regDst, Rt);
        expectFetch();
    endtask

    // both outcomes per branch with mask order beq bgez blez bltz bne bgtz
    task automatic branchTest(input logic [31:0] instr, input int idx);
        logic [5:0] cond;
        cond = lcgNext() >> 26;
        for (int pass = 0; pass < 2; pass++)
        begin
            @(posedge clk);
            branchCond <= cond;
            fetchDecode(instr);
            @(negedge clk);
            checkVal("pcWrite", pcWrite, cond[idx]);
            checkVal("aluSrcA", aluSrcA, `SRCA_PC);
            checkVal("aluSrcB", aluSrcB, Offset);
            checkVal("regWrite", regWrite, 1'b0);
            expectFetch();
            cond = ~cond;
        end
    endtask

    task automatic jumpTest(input logic [5:0] op, input logic link);
        fetchDecode({op, 26'h0_1234});
        @(negedge clk);
        checkVal("pcWrite", pcWrite, 1'b1);
        checkVal("pcSrc", pcSrc, PcLongJump);
        checkVal("regWrite", regWrite, link);
        if (link)
            checkVal("regDst", regDst, Ra31);
        expectFetch();
    endtask

    task automatic loadTest();
        fetchDecode({`OP_LW, 5'd1, 5'd7, 16'h0010});
        @(negedge clk);
        checkVal("aluWrite", aluWrite, 1'b1);
        checkVal("aluSrcB", aluSrcB, ImmSigned);
        @(negedge clk);
        checkVal("memRead", memRead, 1'b1);
        checkVal("iorD", iorD, `IORD_ALUOUT);
        holdLevel("memRead", LVL_MEM_READ, randDelay());
        driveAck(ACK_MEM);
        @(negedge clk);
        checkVal("memRead", memRead, 1'b0);
        checkVal("readDataAck", readDataAck, 1'b1);
        checkVal("readDataWrite", readDataWrite, 1'b1);
        holdLevel("readDataAck", LVL_READ_ACK, randDelay());
        driveAck(ACK_READ);
        @(negedge clk);
        checkVal("readDataAck", readDataAck, 1'b0);
        checkVal("regWrite", regWrite, 1'b1);
        checkVal("regWriteSrc", regWriteSrc, WbMem);
        expectFetch();
    endtask

    task automatic storeTest();
        fetchDecode({`OP_SW, 5'd1, 5'd7, 16'hfffc});
        @(negedge clk);
        checkVal("aluWrite", aluWrite, 1'b1);
        checkVal("aluSrcB", aluSrcB, ImmSigned);
        @(negedge clk);
        checkVal("memWrite", memWrite, 1'b1);
        checkVal("memWriteSrc", memWriteSrc, 1'b1);
        checkVal("iorD", iorD, `IORD_ALUOUT);
        holdLevel("memWrite", LVL_MEM_WRITE, randDelay());
        driveAck(ACK_MEM);
        expectFetch();
    endtask

    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT);
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        instruction = '0;
        branchCond = '0;
        specialJump = 1'b0;
        instReqAck = 1'b0;
        instValid = 1'b0;
        memReqAck = 1'b0;
        readDataValid = 1'b0;
        checks = 0;
        errors = 0;
        resetTest();
        // addu, jr, jalr
        rTypeTest(6'h21, 1'b0, `SRCA_A, B);
        rTypeTest(6'h08, 1'b1, `SRCA_A, B);
        rTypeTest(`FN_JALR, 1'b1, `SRCA_PC, Four);
        immTest(`OP_ADDIU, `ALU_ADD, ImmSigned);
        immTest(`OP_SLTI, `ALU_SLT, ImmSigned);
        immTest(`OP_SLTIU, `ALU_SLTU, ImmSigned);
        immTest(`OP_ANDI, `ALU_AND, ImmUnsigned);
        immTest(`OP_ORI, `ALU_OR, ImmUnsigned);
        immTest(`OP_XORI, `ALU_XOR, ImmUnsigned);
        branchTest({`OP_BEQ, 5'd1, 5'd2, 16'h0004}, 0);
        branchTest({`OP_REGIMM, 5'd1, `RT_BGEZ, 16'h0008}, 1);
        branchTest({`OP_BLEZ, 5'd1, 5'd0, 16'hfff0}, 2);
        branchTest({`OP_REGIMM, 5'd1, `RT_BLTZ, 16'h0002}, 3);
        branchTest({`OP_BNE, 5'd3, 5'd4, 16'h0010}, 4);
        branchTest({`OP_BGTZ, 5'd5, 5'd0, 16'hff00}, 5);
        jumpTest(`OP_JAL, 1'b1);
        jumpTest(`OP_J, 1'b0);
        // unused opcode goes straight back to fetch
        fetchDecode(32'hfc00_0000);
        expectFetch();
        loadTest();
        storeTest();
        loadTest();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== source/mipsCtrl.sv ====
`timescale 1ns/1ps
`include "mipsCtrl_macros.svh"

module mipsCtrl
    import mipsCtrlPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`WORD_W-1:0]   instruction,
    input  logic [`BRANCH_W-1:0] branchCond,
    input  logic                 specialJump,
    input  logic                 instReqAck,
    input  logic                 instValid,
    input  logic                 memReqAck,
    input  logic                 readDataValid,
    output logic                 pcWrite,
    output logic                 memRead,
    output logic                 memWrite,
    output logic                 regWrite,
    output logic                 aWrite,
    output logic                 bWrite,
    output logic                 instructionWrite,
    output logic                 aluSrcA,
    output logic                 aluOpSrc,
    output logic                 aluWrite,
    output logic                 memWriteSrc,
    output logic                 iorD,
    output logic                 instReqValid,
    output logic                 instAck,
    output logic                 readDataAck,
    output logic                 readDataWrite,
    output aluSrcBT              aluSrcB,
    output pcSrcT                pcSrc,
    output regWriteSrcT          regWriteSrc,
    output regDstT               regDst,
    output logic [`ALUOP_W-1:0]  aluOpC
);

    instWordT  instWord;
    ctrlStateT nextState;

    assign instWord = instruction;

    decodeIf decBus();

    instDecoder decoder0 (
        .instruction (instWord),
        .dec         (decBus.producer)
    );

    ctrlFsm fsm0 (
        .clk           (clk),
        .rst           (rst),
        .dec           (decBus.consumer),
        .instReqAck    (instReqAck),
        .instValid     (instValid),
        .memReqAck     (memReqAck),
        .readDataValid (readDataValid),
        .nextState     (nextState)
    );

    ctrlSignals signals0 (
        .clk              (clk),
        .rst              (rst),
        .nextState        (nextState),
        .dec              (decBus.consumer),
        .branchCond       (branchCond),
        .specialJump      (specialJump),
        .pcWrite          (pcWrite),
        .memRead          (memRead),
        .memWrite         (memWrite),
        .regWrite         (regWrite),
        .aWrite           (aWrite),
        .bWrite           (bWrite),
        .instructionWrite (instructionWrite),
        .aluSrcA          (aluSrcA),
        .aluOpSrc         (aluOpSrc),
        .aluWrite         (aluWrite),
        .memWriteSrc      (memWriteSrc),
        .iorD             (iorD),
        .instReqValid     (instReqValid),
        .instAck          (instAck),
        .readDataAck      (readDataAck),
        .readDataWrite    (readDataWrite),
        .aluSrcB          (aluSrcB),
        .pcSrc            (pcSrc),
        .regWriteSrc      (regWriteSrc),
        .regDst           (regDst),
        .aluOpC           (aluOpC)
    );

endmodule

// ==== source/ctrlSignals.sv ====
`timescale 1ns/1ps
`include "mipsCtrl_macros.svh"

module ctrlSignals
    import mipsCtrlPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  ctrlStateT            nextState,
    decodeIf.consumer            dec,
    input  logic [`BRANCH_W-1:0] branchCond,
    input  logic                 specialJump,
    output logic                 pcWrite,
    output logic                 memRead,
    output logic                 memWrite,
    output logic                 regWrite,
    output logic                 aWrite,
    output logic                 bWrite,
    output logic                 instructionWrite,
    output logic                 aluSrcA,
    output logic                 aluOpSrc,
    output logic                 aluWrite,
    output logic                 memWriteSrc,
    output logic                 iorD,
    output logic                 instReqValid,
    output logic                 instAck,
    output logic                 readDataAck,
    output logic                 readDataWrite,
    output aluSrcBT              aluSrcB,
    output pcSrcT                pcSrc,
    output regWriteSrcT          regWriteSrc,
    output regDstT               regDst,
    output logic [`ALUOP_W-1:0]  aluOpC
);

    // the word is latched for the state being entered
    always_ff @(posedge clk)
    begin
        pcWrite          <= 1'b0;
        memRead          <= 1'b0;
        memWrite         <= 1'b0;
        regWrite         <= 1'b0;
        aWrite           <= 1'b0;
        bWrite           <= 1'b0;
        instructionWrite <= 1'b0;
        aluSrcA          <= `SRCA_A;
        aluOpSrc         <= `OPSRC_CTRL;
        aluWrite         <= 1'b0;
        memWriteSrc      <= `MWSRC_ALUOUT;
        iorD             <= `IORD_ALUOUT;
        instReqValid     <= 1'b0;
        instAck          <= 1'b0;
        readDataAck      <= 1'b0;
        readDataWrite    <= 1'b0;
        aluSrcB          <= B;
        pcSrc            <= PcAlu;
        regWriteSrc      <= WbAluOut;
        regDst           <= Rt;
        aluOpC           <= `ALU_ADD;
        if (rst)
        begin
            // response side stays ready through reset
            instAck <= 1'b1;
            aluOpC  <= '0;
        end
        else
        begin
            case (nextState)
                Fetch:
                begin
                    // precompute PC + 4 while the request is out
                    instReqValid <= 1'b1;
                    aluSrcA      <= `SRCA_PC;
                    aluSrcB      <= Four;
                    aluWrite     <= 1'b1;
                    iorD         <= `IORD_PC;
                end
                Fwait:
                begin
                    instAck          <= 1'b1;
                    instructionWrite <= 1'b1;
                    pcWrite          <= 1'b1;
                    pcSrc            <= PcAluOut;
                    iorD             <= `IORD_PC;
                end
                Decode:
                begin
                    aWrite  <= 1'b1;
                    bWrite  <= 1'b1;
                    aluSrcA <= dec.aluSrcA;
                    aluSrcB <= dec.aluSrcB;
                end
                Rexe:
                begin
                    // jr and jalr take the target from A
                    pcWrite  <= specialJump;
                    pcSrc    <= PcA;
                    aluWrite <= 1'b1;
                    aluSrcA  <= dec.aluSrcA;
                    aluSrcB  <= dec.aluSrcB;
                    aluOpSrc <= `OPSRC_FUNCT;
                end
                Bexe:
                begin
                    pcWrite <= |(dec.branchMask & branchCond);
                    aluSrcA <= `SRCA_PC;
                    aluSrcB <= Offset;
                end
                Jexe:
                begin
                    pcWrite     <= 1'b1;
                    pcSrc       <= PcLongJump;
                    // only jal links
                    regWrite    <= (dec.regDst == Ra31);
                    regDst      <= dec.regDst;
                    regWriteSrc <= WbAluNow;
                    aluSrcA     <= `SRCA_PC;
                    aluSrcB     <= Four;
                end
                Iexe, Lexe, Sexe:
                begin
                    aluWrite <= 1'b1;
                    aluSrcB  <= dec.aluSrcB;
                    aluOpC   <= dec.aluOp;
                end
                Rreg, Ireg:
                begin
                    regWrite <= 1'b1;
                    regDst   <= dec.regDst;
                end
                Lmem:   memRead <= 1'b1;
                Lwait:
                begin
                    readDataAck   <= 1'b1;
                    readDataWrite <= 1'b1;
                end
                Lreg:
                begin
                    regWrite    <= 1'b1;
                    regWriteSrc <= WbMem;
                    regDst      <= dec.regDst;
                end
                Smem:
                begin
                    memWrite    <= 1'b1;
                    memWriteSrc <= `MWSRC_B;
                end
                default:
                begin
                    // Reset state keeps the quiet word
                    aluOpC <= '0;
                end
            endcase
        end
    end

endmodule

// ==== source/ctrlFsm.sv ====
`timescale 1ns/1ps

module ctrlFsm
    import mipsCtrlPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    decodeIf.consumer  dec,
    input  logic       instReqAck,
    input  logic       instValid,
    input  logic       memReqAck,
    input  logic       readDataValid,
    output ctrlStateT  nextState
);

    ctrlStateT state;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= Reset;
        else
            state <= nextState;
    end

    always_comb
    begin
        case (state)
            Reset:  nextState = Fetch;
            Fetch:  nextState = instReqAck ? Fwait : Fetch;
            Fwait:  nextState = instValid ? Decode : Fwait;
            Decode:
            begin
                // dispatch on the instruction class
                case (dec.instClass)
                    RType:   nextState = Rexe;
                    Branch:  nextState = Bexe;
                    Jump:    nextState = Jexe;
                    Imm:     nextState = Iexe;
                    Load:    nextState = Lexe;
                    Store:   nextState = Sexe;
                    default: nextState = Fetch;
                endcase
            end
            Rexe:   nextState = Rreg;
            Rreg:   nextState = Fetch;
            Bexe:   nextState = Fetch;
            Jexe:   nextState = Fetch;
            Iexe:   nextState = Ireg;
            Ireg:   nextState = Fetch;
            Lexe:   nextState = Lmem;
            Lmem:   nextState = memReqAck ? Lwait : Lmem;
            Lwait:  nextState = readDataValid ? Lreg : Lwait;
            Lreg:   nextState = Fetch;
            Sexe:   nextState = Smem;
            Smem:   nextState = memReqAck ? Fetch : Smem;
            // not one-hot, restart at fetch
            default: nextState = Fetch;
        endcase
    end

endmodule

// ==== source/instDecoder.sv ====
`timescale 1ns/1ps
`include "mipsCtrl_macros.svh"

module instDecoder
    import mipsCtrlPkg::*;
(
    input instWordT    instruction,
    decodeIf.producer  dec
);

    logic [`OP_W-1:0]      opcode;
    logic                  isRegimm;
    logic                  isJalr;
    logic [`BRANCH_W-1:0]  brMask;

    assign opcode   = instruction.r.opcode;
    assign isRegimm = (opcode == `OP_REGIMM);
    assign isJalr   = (opcode == `OP_SPECIAL) && (instruction.r.funct == `FN_JALR);

    // bltz and bgez share an opcode, rt picks which
    assign brMask = {
        opcode == `OP_BGTZ,
        opcode == `OP_BNE,
        isRegimm && (instruction.i.rt == `RT_BLTZ),
        opcode == `OP_BLEZ,
        isRegimm && (instruction.i.rt == `RT_BGEZ),
        opcode == `OP_BEQ
    };

    assign dec.branchMask = brMask;

    // jalr link address and branch compare run off the PC
    assign dec.aluSrcA = (isJalr || (|brMask)) ? `SRCA_PC : `SRCA_A;

    always_comb
    begin
        dec.instClass = Unknown;
        dec.aluSrcB   = B;
        dec.aluOp     = `ALU_ADD;
        dec.regDst    = Rt;
        case (opcode)
            `OP_SPECIAL:
            begin
                dec.instClass = RType;
                dec.regDst    = Rd;
                dec.aluSrcB   = isJalr ? Four : B;
            end
            `OP_REGIMM, `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ:
            begin
                // REGIMM with an rt we do not know falls to Unknown
                dec.instClass = (|brMask) ? Branch : Unknown;
            end
            `OP_J:
            begin
                dec.instClass = Jump;
            end
            `OP_JAL:
            begin
                dec.instClass = Jump;
                dec.regDst    = Ra31;
            end
            `OP_ADDIU, `OP_SLTI, `OP_SLTIU:
            begin
                dec.instClass = Imm;
                dec.aluSrcB   = ImmSigned;
                if (opcode == `OP_SLTI)
                    dec.aluOp = `ALU_SLT;
                else if (opcode == `OP_SLTIU)
                    dec.aluOp = `ALU_SLTU;
            end
            `OP_ANDI, `OP_ORI, `OP_XORI:
            begin
                dec.instClass = Imm;
                dec.aluSrcB   = ImmUnsigned;
                if (opcode == `OP_ANDI)
                    dec.aluOp = `ALU_AND;
                else if (opcode == `OP_ORI)
                    dec.aluOp = `ALU_OR;
                else
                    dec.aluOp = `ALU_XOR;
            end
            `OP_LW:
            begin
                dec.instClass = Load;
                dec.aluSrcB   = ImmSigned;
            end
            `OP_SW:
            begin
                dec.instClass = Store;
                dec.aluSrcB   = ImmSigned;
            end
            default:
            begin
                dec.instClass = Unknown;
            end
        endcase
    end

endmodule

// ==== source/decodeIf.sv ====
`timescale 1ns/1ps
`include "mipsCtrl_macros.svh"

interface decodeIf
    import mipsCtrlPkg::*;
();

    instClassT           instClass;
    logic                aluSrcA;
    aluSrcBT             aluSrcB;
    logic [`ALUOP_W-1:0] aluOp;
    // one-hot in the order beq bgez blez bltz bne bgtz
    logic [`BRANCH_W-1:0] branchMask;
    regDstT              regDst;

    modport producer (
        output instClass, aluSrcA, aluSrcB, aluOp, branchMask, regDst
    );

    modport consumer (
        input instClass, aluSrcA, aluSrcB, aluOp, branchMask, regDst
    );

endinterface

// ==== source/mipsCtrlPkg.sv ====
`include "mipsCtrl_macros.svh"

package mipsCtrlPkg;

    typedef struct packed {
        logic [`OP_W-1:0]    opcode;
        logic [`REG_W-1:0]   rs;
        logic [`REG_W-1:0]   rt;
        logic [`REG_W-1:0]   rd;
        logic [`REG_W-1:0]   shamt;
        logic [`FUNCT_W-1:0] funct;
    } rFormatT;

    typedef struct packed {
        logic [`OP_W-1:0]                      opcode;
        logic [`REG_W-1:0]                     rs;
        logic [`REG_W-1:0]                     rt;
        logic [`WORD_W-`OP_W-2*`REG_W-1:0]     imm;
    } iFormatT;

    typedef struct packed {
        logic [`OP_W-1:0]        opcode;
        logic [`WORD_W-`OP_W-1:0] target;
    } jFormatT;

    // one instruction word, viewed in whichever format the opcode implies
    typedef union packed {
        rFormatT r;
        iFormatT i;
        jFormatT j;
    } instWordT;

    // one-hot controller states
    typedef enum logic [15:0] {
        Reset  = 16'h0001,
        Fetch  = 16'h0002,
        Fwait  = 16'h0004,
        Decode = 16'h0008,
        Rexe   = 16'h0010,
        Rreg   = 16'h0020,
        Bexe   = 16'h0040,
        Jexe   = 16'h0080,
        Iexe   = 16'h0100,
        Ireg   = 16'h0200,
        Lexe   = 16'h0400,
        Lmem   = 16'h0800,
        Lwait  = 16'h1000,
        Lreg   = 16'h2000,
        Sexe   = 16'h4000,
        Smem   = 16'h8000
    } ctrlStateT;

    typedef enum logic [2:0] {RType, Branch, Jump, Imm, Load, Store, Unknown} instClassT;

    typedef enum logic [2:0] {
        B           = 3'd0,
        Four        = 3'd2,
        ImmSigned   = 3'd3,
        ImmUnsigned = 3'd4,
        Offset      = 3'd5
    } aluSrcBT;

    typedef enum logic [1:0] {PcAlu, PcAluOut, PcA, PcLongJump} pcSrcT;

    typedef enum logic [1:0] {WbAluOut, WbMem, WbAluNow} regWriteSrcT;

    typedef enum logic [1:0] {Rt, Rd, Ra31} regDstT;

endpackage

// ==== source/mipsCtrl_macros.svh ====
`ifndef MIPSCTRL_MACROS_SVH
`define MIPSCTRL_MACROS_SVH

// field widths
`define WORD_W    32
`define OP_W      6
`define FUNCT_W   6
`define REG_W     5
`define ALUOP_W   3
`define BRANCH_W  6

// opcodes
`define OP_SPECIAL 6'b000000
`define OP_REGIMM  6'b000001
`define OP_J       6'b000010
`define OP_JAL     6'b000011
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_BLEZ    6'b000110
`define OP_BGTZ    6'b000111
`define OP_ADDIU   6'b001001
`define OP_SLTI    6'b001010
`define OP_SLTIU   6'b001011
`define OP_ANDI    6'b001100
`define OP_ORI     6'b001101
`define OP_XORI    6'b001110
`define OP_LW      6'b100011
`define OP_SW      6'b101011

`define FN_JALR    6'b001001

// rt field under REGIMM
`define RT_BLTZ    5'b00000
`define RT_BGEZ    5'b00001

// ALU operation codes
`define ALU_AND    3'b000
`define ALU_OR     3'b001
`define ALU_ADD    3'b010
`define ALU_SLTU   3'b011
`define ALU_XOR    3'b100
`define ALU_SLT    3'b111

// single-bit mux selects
`define SRCA_A       1'b0
`define SRCA_PC      1'b1
`define IORD_PC      1'b0
`define IORD_ALUOUT  1'b1
`define OPSRC_CTRL   1'b0
`define OPSRC_FUNCT  1'b1
`define MWSRC_ALUOUT 1'b0
`define MWSRC_B      1'b1

`endif
